/* hw/rename_cfg.svh */
// sizes for the rename core; N_ROB must be a power of two
// N_PREG must exceed N_AREG + 1 so that reset leaves free tags
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

`define N_WAY  2   // dispatch and retire width
`define N_ROB  8   // reorder buffer entries
`define N_PREG 32  // physical registers, tag 0 reserved
`define N_AREG 8   // architectural registers

`endif

/* hw/rename_pkg.sv */
// shared types of the rename core, widths follow rename_cfg.svh
// tag 0 is the "no tag" value and is never allocated
`include "rename_cfg.svh"

package rename_pkg;

	// physical register tag
	typedef logic [$clog2(`N_PREG)-1:0] preg_tag_t;

	// architectural register number
	typedef logic [$clog2(`N_AREG)-1:0] areg_t;

	// 0 .. N_ROB inclusive
	typedef logic [$clog2(`N_ROB+1)-1:0] rob_count_t;

	// 0 .. N_PREG inclusive
	typedef logic [$clog2(`N_PREG+1)-1:0] free_count_t;

endpackage

/* hw/rob_dispatch_if.sv */
// dispatch packets from the rename map into the ROB
// valid marks accepted ways only, the ROB writes them in way order
`timescale 1ns/10ps
`include "rename_cfg.svh"

interface rob_dispatch_if;
	import rename_pkg::*;

	logic [`N_WAY-1:0] valid;
	preg_tag_t [`N_WAY-1:0] tag; // newly allocated tag
	preg_tag_t [`N_WAY-1:0] tag_old; // previous mapping of the dest
	logic [`N_WAY-1:0] branch_inst;

	modport rename (
		output valid,
		output tag,
		output tag_old,
		output branch_inst
	);

	modport rob (
		input valid,
		input tag,
		input tag_old,
		input branch_inst
	);

endinterface

/* hw/rob_retire_if.sv */
// retirement and squash from the ROB to the free list and rename map
// squash_tags is only meaningful while squash is high, 0 otherwise
`timescale 1ns/10ps
`include "rename_cfg.svh"

interface rob_retire_if;
	import rename_pkg::*;

	logic [`N_WAY-1:0] retire_valid;
	preg_tag_t [`N_WAY-1:0] retire_tag;  // becomes the committed mapping
	preg_tag_t [`N_WAY-1:0] retire_told; // goes back to the free list
	logic squash;
	preg_tag_t [`N_ROB-1:0] squash_tags; // one per ROB entry, 0 if empty

	modport rob (
		output retire_valid,
		output retire_tag,
		output retire_told,
		output squash,
		output squash_tags
	);

	modport user (
		input retire_valid,
		input retire_tag,
		input retire_told,
		input squash,
		input squash_tags
	);

endinterface

/* hw/free_list.sv */
// bitmap free list, lowest free tags offered first
// take must only mark offered tags that are nonzero
`timescale 1ns/10ps
`include "rename_cfg.svh"

module free_list (
	input logic clock,
	input logic reset,
	input logic [`N_WAY-1:0] take,
	output rename_pkg::preg_tag_t [`N_WAY-1:0] free_tags,
	output rename_pkg::free_count_t free_count,
	rob_retire_if.user ret
);
	import rename_pkg::*;

	logic [`N_PREG-1:0] free_q, free_d;
	free_count_t count_q, count_d;

	assign free_count = count_q;

	// priority encoders, one per way, each skipping what the lower ways took
	always_comb begin
		logic [`N_PREG-1:0] avail;
		logic found;
		avail = free_q;
		for (int w = 0; w < `N_WAY; w++) begin
			free_tags[w] = '0;
			found = 1'b0;
			for (int i = 1; i < `N_PREG; i++) begin // tag 0 never offered
				if (avail[i] && !found) begin
					free_tags[w] = preg_tag_t'(i);
					avail[i] = 1'b0;
					found = 1'b1;
				end
			end
		end
	end

	always_comb begin
		free_d = free_q;
		for (int w = 0; w < `N_WAY; w++)
			if (take[w] && free_tags[w] != '0)
				free_d[free_tags[w]] = 1'b0;
		for (int w = 0; w < `N_WAY; w++)
			if (ret.retire_valid[w] && ret.retire_told[w] != '0)
				free_d[ret.retire_told[w]] = 1'b1;
		if (ret.squash)
			for (int i = 0; i < `N_ROB; i++)
				if (ret.squash_tags[i] != '0)
					free_d[ret.squash_tags[i]] = 1'b1;
		count_d = '0;
		for (int i = 0; i < `N_PREG; i++)
			count_d = count_d + free_count_t'(free_d[i]); // popcount
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `N_PREG; i++)
				free_q[i] <= (i > `N_AREG); // tags 1..N_AREG hold the reset map
			count_q <= free_count_t'(`N_PREG - `N_AREG - 1);
		end else begin
			free_q <= free_d;
			count_q <= count_d;
		end
	end

	for (genvar w = 0; w < `N_WAY; w++) begin : g_chk
		// retiring told must still be held by the ROB
		a_told_not_free: assert property (@(posedge clock) disable iff (reset)
			(ret.retire_valid[w] && ret.retire_told[w] != '0) |-> !free_q[ret.retire_told[w]])
			else $error("retired told %0d already free", ret.retire_told[w]);
		// the map may only take a real tag
		a_no_tag0: assert property (@(posedge clock) disable iff (reset)
			take[w] |-> free_tags[w] != '0)
			else $error("tag 0 allocated on way %0d", w);
	end

	for (genvar i = 0; i < `N_ROB; i++) begin : g_sq_chk
		a_squash_not_free: assert property (@(posedge clock) disable iff (reset)
			(ret.squash && ret.squash_tags[i] != '0) |-> !free_q[ret.squash_tags[i]])
			else $error("squashed tag %0d already free", ret.squash_tags[i]);
	end

endmodule

/* hw/rename_map.sv */
// speculative and retirement map tables plus the dispatch acceptance
// a way is refused once a lower valid way is refused; no back-pressure
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_map (
	input logic clock,
	input logic reset,
	input logic [`N_WAY-1:0] dispatch_valid,
	input rename_pkg::areg_t [`N_WAY-1:0] dispatch_dest,
	input logic [`N_WAY-1:0] dispatch_branch,
	output logic [`N_WAY-1:0] dispatched,
	output rename_pkg::preg_tag_t [`N_WAY-1:0] dispatch_tag,
	input rename_pkg::preg_tag_t [`N_WAY-1:0] free_tags,
	input rename_pkg::free_count_t free_count,
	output logic [`N_WAY-1:0] take,
	input rename_pkg::rob_count_t rob_space,
	input logic squash,
	rob_dispatch_if.rename dis,
	rob_retire_if.user ret
);
	import rename_pkg::*;

	preg_tag_t spec_q [`N_AREG]; // speculative map
	preg_tag_t spec_d [`N_AREG];
	preg_tag_t retr_q [`N_AREG]; // committed map
	preg_tag_t retr_d [`N_AREG];

	// accept in way order while ROB entries and free tags last
	always_comb begin
		int n_acc;
		logic stop;
		n_acc = 0;
		stop = squash; // nothing dispatches in the squash cycle
		take = '0;
		for (int w = 0; w < `N_WAY; w++) begin
			dispatched[w] = 1'b0;
			dispatch_tag[w] = '0;
			if (dispatch_valid[w] && !stop) begin
				if (n_acc < int'(rob_space) && n_acc < int'(free_count)) begin
					dispatched[w] = 1'b1;
					dispatch_tag[w] = free_tags[n_acc];
					take[n_acc] = 1'b1;
					n_acc++;
				end else begin
					stop = 1'b1;
				end
			end
		end
	end

	// old mapping, with bypass from an earlier way writing the same dest
	always_comb begin
		for (int w = 0; w < `N_WAY; w++) begin
			dis.tag_old[w] = spec_q[dispatch_dest[w]];
			for (int j = 0; j < w; j++)
				if (dispatched[j] && dispatch_dest[j] == dispatch_dest[w])
					dis.tag_old[w] = dispatch_tag[j]; // latest earlier way wins
		end
	end

	assign dis.valid = dispatched;
	assign dis.tag = dispatch_tag;
	assign dis.branch_inst = dispatch_branch;

	always_comb begin
		spec_d = spec_q;
		retr_d = retr_q;
		// the retiring told is the committed mapping of the dest, so find it there
		for (int w = 0; w < `N_WAY; w++)
			if (ret.retire_valid[w])
				for (int r = 0; r < `N_AREG; r++)
					if (retr_d[r] == ret.retire_told[w])
						retr_d[r] = ret.retire_tag[w];
		if (ret.squash) begin
			spec_d = retr_q; // nothing retires in a squash cycle
		end else begin
			for (int w = 0; w < `N_WAY; w++)
				if (dispatched[w])
					spec_d[dispatch_dest[w]] = dispatch_tag[w];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < `N_AREG; r++) begin
				spec_q[r] <= preg_tag_t'(r + 1); // areg r -> tag r+1
				retr_q[r] <= preg_tag_t'(r + 1);
			end
		end else begin
			spec_q <= spec_d;
			retr_q <= retr_d;
		end
	end

endmodule

/* hw/rob.sv */
// circular reorder buffer, retires up to N_WAY per cycle in order
// a completed taken branch at the head squashes every entry, itself included
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rob (
	input logic clock,
	input logic reset,
	input rename_pkg::preg_tag_t [`N_WAY-1:0] complete_tag,
	input logic [`N_WAY-1:0] complete_taken,
	rob_dispatch_if.rob dis,
	rob_retire_if.rob ret,
	output rename_pkg::rob_count_t rob_space
);
	import rename_pkg::*;

	localparam int PTR_W = $clog2(`N_ROB);

	// entry payload
	preg_tag_t tag_q [`N_ROB];
	preg_tag_t told_q [`N_ROB];
	logic [`N_ROB-1:0] br_q;
	preg_tag_t tag_d [`N_ROB];
	preg_tag_t told_d [`N_ROB];
	logic [`N_ROB-1:0] br_d;

	// entry status and pointers
	logic [`N_ROB-1:0] done_q, done_d;
	logic [`N_ROB-1:0] taken_q, taken_d;
	logic [PTR_W-1:0] head_q, head_d;
	logic [PTR_W-1:0] tail_q, tail_d; // next entry to write
	rob_count_t count_q, count_d;

	logic [`N_ROB-1:0] occupied;
	rob_count_t n_ret;
	rob_count_t space;

	always_comb begin
		logic [PTR_W-1:0] offset;
		for (int i = 0; i < `N_ROB; i++) begin
			offset = PTR_W'(i) - head_q;
			occupied[i] = rob_count_t'(offset) < count_q;
		end
	end

	// retire step, from registered state only
	always_comb begin
		logic stop;
		logic [PTR_W-1:0] idx;
		ret.squash = count_q != '0 && done_q[head_q] && br_q[head_q] && taken_q[head_q];
		stop = ret.squash;
		n_ret = '0;
		for (int w = 0; w < `N_WAY; w++) begin
			idx = head_q + PTR_W'(w);
			ret.retire_valid[w] = 1'b0;
			ret.retire_tag[w] = '0;
			ret.retire_told[w] = '0;
			if (!stop && rob_count_t'(w) < count_q && done_q[idx]
					&& !(br_q[idx] && taken_q[idx])) begin
				ret.retire_valid[w] = 1'b1;
				ret.retire_tag[w] = tag_q[idx];
				ret.retire_told[w] = told_q[idx];
				n_ret = n_ret + rob_count_t'(1);
			end else begin
				stop = 1'b1; // stays in order, also halts at a taken branch
			end
		end
		for (int i = 0; i < `N_ROB; i++)
			ret.squash_tags[i] = (ret.squash && occupied[i]) ? tag_q[i] : '0;
	end

	// entries retiring this cycle count as free
	assign space = rob_count_t'(`N_ROB) - count_q + n_ret;
	assign rob_space = (space > rob_count_t'(`N_WAY)) ? rob_count_t'(`N_WAY) : space;

	// complete then dispatch, both dropped on squash
	always_comb begin
		logic [PTR_W-1:0] ptr;
		rob_count_t n_dis;
		tag_d = tag_q;
		told_d = told_q;
		br_d = br_q;
		done_d = done_q;
		taken_d = taken_q;
		ptr = tail_q;
		n_dis = '0;
		if (!ret.squash) begin
			for (int w = 0; w < `N_WAY; w++)
				for (int i = 0; i < `N_ROB; i++)
					if (complete_tag[w] != '0 && occupied[i] && tag_q[i] == complete_tag[w]) begin
						done_d[i] = 1'b1;
						taken_d[i] = complete_taken[w];
					end
			for (int w = 0; w < `N_WAY; w++)
				if (dis.valid[w]) begin
					tag_d[ptr] = dis.tag[w];
					told_d[ptr] = dis.tag_old[w];
					br_d[ptr] = dis.branch_inst[w];
					done_d[ptr] = 1'b0;
					taken_d[ptr] = 1'b0;
					ptr = ptr + PTR_W'(1);
					n_dis = n_dis + rob_count_t'(1);
				end
		end
		if (ret.squash) begin
			head_d = head_q;
			tail_d = head_q; // empty
			count_d = '0;
		end else begin
			head_d = head_q + PTR_W'(n_ret);
			tail_d = ptr;
			count_d = count_q - n_ret + n_dis;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			done_q <= '0;
			taken_q <= '0;
		end else begin
			head_q <= head_d;
			tail_q <= tail_d;
			count_q <= count_d;
			done_q <= done_d;
			taken_q <= taken_d;
		end
	end

	always_ff @(posedge clock) begin
		tag_q <= tag_d;
		told_q <= told_d;
		br_q <= br_d;
	end

	// the rename map must honour rob_space
	a_no_overflow: assert property (@(posedge clock) disable iff (reset)
		rob_count_t'($countones(dis.valid)) <= rob_space)
		else $error("dispatch beyond free ROB entries");

	a_no_dispatch_on_squash: assert property (@(posedge clock) disable iff (reset)
		ret.squash |-> dis.valid == '0)
		else $error("dispatch during squash");

	for (genvar w = 0; w < `N_WAY; w++) begin : g_chk
		a_retire_tag: assert property (@(posedge clock) disable iff (reset)
			ret.retire_valid[w] |-> ret.retire_tag[w] != '0)
			else $error("retired tag 0 on way %0d", w);
	end

endmodule

/* hw/rename_core.sv */
// rename and retirement core top, dispatch and completion are strobes
// an unaccepted instruction must be presented again by the source
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_core (
	input logic clock,
	input logic reset,
	input logic [`N_WAY-1:0] dispatch_valid,
	input rename_pkg::areg_t [`N_WAY-1:0] dispatch_dest,
	input logic [`N_WAY-1:0] dispatch_branch,
	output logic [`N_WAY-1:0] dispatched,
	output rename_pkg::preg_tag_t [`N_WAY-1:0] dispatch_tag,
	input rename_pkg::preg_tag_t [`N_WAY-1:0] complete_tag,
	input logic [`N_WAY-1:0] complete_taken,
	output logic [`N_WAY-1:0] retire_valid,
	output rename_pkg::preg_tag_t [`N_WAY-1:0] retire_tag,
	output rename_pkg::preg_tag_t [`N_WAY-1:0] retire_told,
	output logic squash,
	output rename_pkg::free_count_t free_count
);
	import rename_pkg::*;

	preg_tag_t [`N_WAY-1:0] free_tags;
	logic [`N_WAY-1:0] take;
	rob_count_t rob_space;

	rob_dispatch_if dis_bus ();
	rob_retire_if ret_bus ();

	rename_map map0 (
		.clock, .reset,
		.dispatch_valid, .dispatch_dest, .dispatch_branch,
		.dispatched, .dispatch_tag,
		.free_tags, .free_count, .take,
		.rob_space, .squash(ret_bus.squash),
		.dis(dis_bus.rename), .ret(ret_bus.user)
	);

	free_list free0 (
		.clock, .reset,
		.take, .free_tags, .free_count,
		.ret(ret_bus.user)
	);

	rob rob0 (
		.clock, .reset,
		.complete_tag, .complete_taken,
		.dis(dis_bus.rob), .ret(ret_bus.rob),
		.rob_space
	);

	assign retire_valid = ret_bus.retire_valid;
	assign retire_tag = ret_bus.retire_tag;
	assign retire_told = ret_bus.retire_told;
	assign squash = ret_bus.squash;

endmodule

/* verif/rename_core_tb.sv */
// directed and random tests of the rename core against a small reference model
// the step task drives exactly two ways, so N_WAY must stay 2
`timescale 1ns/10ps
`include "rename_cfg.svh"

module rename_core_tb;
	import rename_pkg::*;

	localparam int MAX_CYCLES = 3000; // tests need about 400, random stream and drains

	logic clock = 1'b0;
	logic reset;
	logic [`N_WAY-1:0] dispatch_valid, dispatch_branch, complete_taken;
	areg_t [`N_WAY-1:0] dispatch_dest;
	preg_tag_t [`N_WAY-1:0] complete_tag;
	logic [`N_WAY-1:0] dispatched, retire_valid;
	preg_tag_t [`N_WAY-1:0] dispatch_tag, retire_tag, retire_told;
	logic squash;
	free_count_t free_count;

	// reference model state
	preg_tag_t m_spec [`N_AREG];
	preg_tag_t m_retr [`N_AREG];
	logic [`N_PREG-1:0] m_free;
	preg_tag_t q_tag[$], q_told[$];
	areg_t q_dest[$];
	logic q_br[$], q_done[$], q_taken[$];

	// DUT outputs seen in the last step
	logic [`N_WAY-1:0] got_dis, got_rv;
	preg_tag_t [`N_WAY-1:0] got_tag, got_rt, got_ro;
	logic got_sq;
	free_count_t got_fc;

	int errors = 0;
	int tests_failed = 0;
	int n_tests = 0;
	int cycles = 0;
	int seed = 32'hb423_e186;

	rename_core dut0 (.*);

	always #10 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run exceeded %0d cycles", MAX_CYCLES);
			$display("Something failed");
			$finish;
		end
	end

	task automatic mismatch(input string msg);
		$display("FAIL %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic int rnd(input int n);
		rnd = int'($unsigned($random(seed)) % n);
	endfunction

	task automatic clear_rob_model();
		q_tag.delete();
		q_told.delete();
		q_dest.delete();
		q_br.delete();
		q_done.delete();
		q_taken.delete();
	endtask

	// one cycle: drive on the falling edge, check, then advance the model
	task automatic step(input logic [1:0] v, input areg_t d0, input areg_t d1,
			input logic [1:0] br, input preg_tag_t c0, input preg_tag_t c1,
			input logic [1:0] ct);
		areg_t d [2];
		preg_tag_t c [2];
		preg_tag_t offer [2];
		preg_tag_t e_tag [2];
		preg_tag_t e_told [2];
		logic [1:0] e_dis, e_rv;
		logic e_sq, stop;
		int n_ret, space, fc, n_acc, k;
		d[0] = d0;
		d[1] = d1;
		c[0] = c0;
		c[1] = c1;
		@(negedge clock);
		dispatch_valid = v;
		dispatch_dest[0] = d0;
		dispatch_dest[1] = d1;
		dispatch_branch = br;
		complete_tag[0] = c0;
		complete_tag[1] = c1;
		complete_taken = ct;
		#1;
		// squash and retire come from the ROB state alone
		e_sq = q_tag.size() > 0 && q_done[0] && q_br[0] && q_taken[0];
		e_rv = '0;
		n_ret = 0;
		stop = e_sq;
		for (int w = 0; w < 2; w++) begin
			if (!stop && w < q_tag.size() && q_done[w] && !(q_br[w] && q_taken[w])) begin
				e_rv[w] = 1'b1;
				n_ret++;
			end else begin
				stop = 1'b1;
			end
		end
		if (squash !== e_sq)
			mismatch($sformatf("squash %b, expected %b", squash, e_sq));
		if (retire_valid !== e_rv)
			mismatch($sformatf("retire_valid %b, expected %b", retire_valid, e_rv));
		for (int w = 0; w < 2; w++)
			if (e_rv[w] && (retire_tag[w] !== q_tag[w] || retire_told[w] !== q_told[w]))
				mismatch($sformatf("way %0d retired %0d/%0d, expected %0d/%0d", w,
					retire_tag[w], retire_told[w], q_tag[w], q_told[w]));
		fc = $countones(m_free);
		if (free_count !== free_count_t'(fc))
			mismatch($sformatf("free_count %0d, expected %0d", free_count, fc));
		// lowest free tags, then the acceptance rule
		offer[0] = '0;
		offer[1] = '0;
		k = 0;
		for (int i = 1; i < `N_PREG; i++)
			if (m_free[i] && k < 2) begin
				offer[k] = preg_tag_t'(i);
				k++;
			end
		space = `N_ROB - q_tag.size() + n_ret;
		if (space > `N_WAY)
			space = `N_WAY;
		n_acc = 0;
		stop = e_sq;
		e_dis = '0;
		for (int w = 0; w < 2; w++) begin
			e_tag[w] = '0;
			if (v[w] && !stop) begin
				if (n_acc < space && n_acc < fc) begin
					e_dis[w] = 1'b1;
					e_tag[w] = offer[n_acc];
					n_acc++;
				end else begin
					stop = 1'b1;
				end
			end
			e_told[w] = m_spec[d[w]];
			for (int j = 0; j < w; j++)
				if (e_dis[j] && d[j] == d[w])
					e_told[w] = e_tag[j]; // same-group bypass
		end
		if (dispatched !== e_dis)
			mismatch($sformatf("dispatched %b, expected %b", dispatched, e_dis));
		for (int w = 0; w < 2; w++)
			if (e_dis[w] && dispatch_tag[w] !== e_tag[w])
				mismatch($sformatf("way %0d got tag %0d, expected %0d", w,
					dispatch_tag[w], e_tag[w]));
		got_dis = dispatched;
		got_tag = dispatch_tag;
		got_rv = retire_valid;
		got_rt = retire_tag;
		got_ro = retire_told;
		got_sq = squash;
		got_fc = free_count;
		// state after the next rising edge
		if (e_sq) begin
			foreach (q_tag[i])
				m_free[q_tag[i]] = 1'b1;
			clear_rob_model();
			m_spec = m_retr;
		end else begin
			for (int w = 0; w < 2; w++)
				foreach (q_tag[i])
					if (c[w] != '0 && q_tag[i] == c[w]) begin
						q_done[i] = 1'b1;
						q_taken[i] = ct[w];
					end
			for (int w = 0; w < n_ret; w++) begin
				if (q_told[0] != '0)
					m_free[q_told[0]] = 1'b1;
				m_retr[q_dest[0]] = q_tag[0];
				void'(q_tag.pop_front());
				void'(q_told.pop_front());
				void'(q_dest.pop_front());
				void'(q_br.pop_front());
				void'(q_done.pop_front());
				void'(q_taken.pop_front());
			end
			for (int w = 0; w < 2; w++)
				if (e_dis[w]) begin
					m_free[e_tag[w]] = 1'b0;
					m_spec[d[w]] = e_tag[w];
					q_tag.push_back(e_tag[w]);
					q_told.push_back(e_told[w]);
					q_dest.push_back(d[w]);
					q_br.push_back(br[w]);
					q_done.push_back(1'b0);
					q_taken.push_back(1'b0);
				end
		end
	endtask

	task automatic idle();
		step(2'b00, '0, '0, 2'b00, '0, '0, 2'b00);
	endtask

	// completes everything in flight, not taken, until the ROB is empty
	task automatic complete_all();
		preg_tag_t c [2];
		int k;
		int guard;
		guard = 0;
		while (q_tag.size() > 0 && guard < 40) begin
			c[0] = '0;
			c[1] = '0;
			k = 0;
			for (int i = 0; i < q_tag.size() && k < 2; i++)
				if (!q_done[i]) begin
					c[k] = q_tag[i];
					k++;
				end
			step(2'b00, '0, '0, 2'b00, c[0], c[1], 2'b00);
			guard++;
		end
		if (q_tag.size() != 0) begin
			$display("error at %0t ns: ROB did not empty within 40 cycles", $time);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int e0);
		n_tests++;
		if (errors == e0) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: %0d errors", name, errors - e0);
			tests_failed++;
		end
	endtask

	task automatic check_reset_state();
		int e0 = errors;
		idle();
		if (got_dis !== 2'b00 || got_rv !== 2'b00 || got_sq !== 1'b0)
			mismatch("strobes not idle after reset");
		if (got_fc !== free_count_t'(23))
			mismatch($sformatf("free_count %0d after reset, expected 23", got_fc));
		report_test("reset state", e0);
	endtask

	task automatic dual_dispatch();
		int e0 = errors;
		step(2'b11, areg_t'(3), areg_t'(3), 2'b00, '0, '0, 2'b00);
		if (got_tag[0] !== preg_tag_t'(9) || got_tag[1] !== preg_tag_t'(10))
			mismatch($sformatf("first tags %0d,%0d, expected 9,10", got_tag[0], got_tag[1]));
		step(2'b00, '0, '0, 2'b00, preg_tag_t'(10), '0, 2'b00); // younger first
		step(2'b00, '0, '0, 2'b00, preg_tag_t'(9), '0, 2'b00);
		if (got_rv !== 2'b00)
			mismatch("retired before the oldest entry completed");
		idle();
		if (got_rv !== 2'b11 || got_ro[0] !== preg_tag_t'(4) || got_ro[1] !== preg_tag_t'(9))
			mismatch($sformatf("retire %b told %0d,%0d, expected 11 told 4,9",
				got_rv, got_ro[0], got_ro[1]));
		idle();
		if (got_fc !== free_count_t'(23))
			mismatch($sformatf("free_count %0d after retire, expected 23", got_fc));
		report_test("dual dispatch", e0);
	endtask

	task automatic full_rob();
		int e0 = errors;
		preg_tag_t head;
		for (int g = 0; g < 4; g++) begin
			step(2'b11, areg_t'(g), areg_t'(g + 4), 2'b00, '0, '0, 2'b00);
			if (g == 0)
				head = got_tag[0];
			if (got_dis !== 2'b11)
				mismatch($sformatf("group %0d dispatched %b, expected 11", g, got_dis));
		end
		step(2'b11, areg_t'(1), areg_t'(2), 2'b00, '0, '0, 2'b00);
		if (got_dis !== 2'b00)
			mismatch("dispatch accepted with the ROB full");
		step(2'b00, '0, '0, 2'b00, head, '0, 2'b00);
		step(2'b11, areg_t'(1), areg_t'(2), 2'b00, '0, '0, 2'b00);
		if (got_rv !== 2'b01 || got_dis !== 2'b01)
			mismatch($sformatf("retire %b dispatch %b, expected 01 and 01", got_rv, got_dis));
		complete_all();
		report_test("full ROB", e0);
	endtask

	task automatic taken_squash();
		int e0 = errors;
		free_count_t fc0;
		preg_tag_t br_tag, t;
		preg_tag_t exp_told;
		idle();
		fc0 = got_fc;
		step(2'b11, areg_t'(1), areg_t'(2), 2'b01, '0, '0, 2'b00);
		br_tag = got_tag[0];
		step(2'b11, areg_t'(3), areg_t'(4), 2'b00, '0, '0, 2'b00);
		step(2'b00, '0, '0, 2'b00, br_tag, '0, 2'b01);
		step(2'b11, areg_t'(5), areg_t'(6), 2'b00, '0, '0, 2'b00);
		if (got_sq !== 1'b1 || got_rv !== 2'b00 || got_dis !== 2'b00)
			mismatch($sformatf("squash %b retire %b dispatch %b, expected 1 00 00",
				got_sq, got_rv, got_dis));
		exp_told = m_retr[1];
		step(2'b01, areg_t'(1), '0, 2'b00, '0, '0, 2'b00);
		t = got_tag[0];
		if (got_fc !== fc0)
			mismatch($sformatf("free_count %0d after squash, expected %0d", got_fc, fc0));
		step(2'b00, '0, '0, 2'b00, t, '0, 2'b00);
		idle();
		if (got_rv !== 2'b01 || got_rt[0] !== t || got_ro[0] !== exp_told)
			mismatch($sformatf("retired told %0d, expected %0d", got_ro[0], exp_told));
		report_test("taken branch squash", e0);
	endtask

	task automatic not_taken_branch();
		int e0 = errors;
		preg_tag_t t;
		preg_tag_t exp_told;
		exp_told = m_retr[5];
		step(2'b01, areg_t'(5), '0, 2'b01, '0, '0, 2'b00);
		t = got_tag[0];
		step(2'b00, '0, '0, 2'b00, t, '0, 2'b00);
		idle();
		if (got_sq !== 1'b0 || got_rv !== 2'b01 || got_rt[0] !== t || got_ro[0] !== exp_told)
			mismatch($sformatf("branch retire %b tag %0d told %0d, squash %b",
				got_rv, got_rt[0], got_ro[0], got_sq));
		report_test("not-taken branch", e0);
	endtask

	task automatic random_stream();
		int e0 = errors;
		preg_tag_t c [2];
		logic [1:0] ct, br;
		int idx;
		int n_ret = 0;
		int n_sq = 0;
		for (int n = 0; n < 300; n++) begin
			for (int w = 0; w < 2; w++) begin
				c[w] = '0;
				ct[w] = 1'b0;
				br[w] = rnd(4) == 0;
				if (q_tag.size() > 0 && rnd(2) == 1) begin
					idx = rnd(q_tag.size());
					c[w] = q_tag[idx];
					ct[w] = q_br[idx] && rnd(3) == 0; // some branches taken
				end
			end
			step(2'(rnd(4)), areg_t'(rnd(8)), areg_t'(rnd(8)), br, c[0], c[1], ct);
			n_ret += $countones(got_rv);
			n_sq += int'(got_sq);
		end
		complete_all();
		$display("random stream: %0d retired, %0d squashes", n_ret, n_sq);
		report_test("random stream", e0);
	endtask

	initial begin
		reset = 1'b1;
		dispatch_valid = '0;
		dispatch_dest = '0;
		dispatch_branch = '0;
		complete_tag = '0;
		complete_taken = '0;
		for (int r = 0; r < `N_AREG; r++) begin
			m_spec[r] = preg_tag_t'(r + 1); // areg r -> tag r+1
			m_retr[r] = preg_tag_t'(r + 1);
		end
		for (int i = 0; i < `N_PREG; i++)
			m_free[i] = i > `N_AREG;
		clear_rob_model();
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_reset_state();
		dual_dispatch();
		full_rob();
		taken_squash();
		not_taken_branch();
		random_stream();
		$display("%0d tests, %0d failed, %0d errors", n_tests, tests_failed, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+hw
hw/rename_pkg.sv
hw/rob_dispatch_if.sv
hw/rob_retire_if.sv
hw/free_list.sv
hw/rename_map.sv
hw/rob.sv
hw/rename_core.sv
verif/rename_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the rename core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert \
	-f all.f \
	--top-module rename_core_tb \
	--Mdir obj_dir -o rename_core_sim

./obj_dir/rename_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Everything OK" sim.log; then
	exit 0
else
	exit 1
fi
